/* lsu_l15.f */
src/lsu_l15_pkg.sv
src/lsu_addr_decode.sv
src/l15_req_fsm.sv
src/load_align.sv
src/lsu_l15_top.sv
test/lsu_l15_checks.sv
test/lsu_l15_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module lsu_l15_tb \
    -f lsu_l15.f \
    --Mdir obj_dir

./obj_dir/Vlsu_l15_tb | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi

/* src/l15_req_fsm.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1.5 request/response FSM with request field formation
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module l15_req_fsm import lsu_l15_pkg::*; (
    input  wire logic      clk,
    input  wire logic      nrst,
    input  wire dec_t      dec,
    input  wire l15_resp_t l15_resp,
    input  wire logic      l15_header_ack,
    output l15_req_t       l15_req,
    output logic           l15_req_ack,
    output logic           hold,
    output mem_op_t        ld_op,
    output logic [1:0]     ld_baddr,
    output logic [1:0]     ld_word_sel,
    output logic           mem_op_done,
    output logic           ld_misaligned,
    output logic           st_misaligned
);

    typedef enum logic {
        S_IDLE,
        S_RESP
    } state_e;

    state_e          state_q;
    logic            rq_store_q;  // type of the request in flight
    logic            req_fire;
    logic            ret_match;
    logic            accept;
    logic [XLEN-1:0] wdata_be;

    // cache side is big endian
    assign wdata_be = {dec.wdata[7:0], dec.wdata[15:8],
                       dec.wdata[23:16], dec.wdata[31:24]};

    always_comb begin
        l15_req.val     = (state_q == S_IDLE) && dec.valid
                          && !dec.ld_mis && !dec.st_mis;
        l15_req.address = dec.addr;
        l15_req.data    = {2{wdata_be}};
        if (dec.bw != 4'b0000) begin
            l15_req.rqtype = STORE_RQ;
            case (dec.bw)
                4'b1111:                   l15_req.size = SIZE_4B;
                4'b0011, 4'b1100:          l15_req.size = SIZE_2B;
                4'b0001, 4'b0010,
                4'b0100, 4'b1000:          l15_req.size = SIZE_1B;
                default:                   l15_req.size = SIZE_0B;
            endcase
        end else begin
            l15_req.rqtype = LOAD_RQ;
            l15_req.size   = SIZE_4B;   // loads fetch the full word
        end
    end

    assign req_fire = l15_req.val && l15_header_ack;

    // a return of the wrong kind is ignored, keep waiting
    assign ret_match = rq_store_q ? (l15_resp.returntype == ST_ACK)
                                  : (l15_resp.returntype == LOAD_RET);
    assign accept    = (state_q == S_RESP) && l15_resp.val && ret_match;

    // pipeline freezes from a pending request up to its matching response
    assign hold = ((state_q == S_IDLE) && l15_req.val)
                  || ((state_q == S_RESP) && !accept);

    assign mem_op_done   = accept;
    assign l15_req_ack   = l15_resp.val;
    assign ld_misaligned = dec.ld_mis;
    assign st_misaligned = dec.st_mis;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q    <= S_IDLE;
            rq_store_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_fire) begin
                        state_q    <= S_RESP;
                        rq_store_q <= (l15_req.rqtype == STORE_RQ);
                    end
                end
                S_RESP: begin
                    if (accept) state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // what the load aligner needs once the data returns
    always_ff @(posedge clk) begin
        if (req_fire) begin
            ld_op       <= dec.op;
            ld_baddr    <= dec.addr[1:0];
            ld_word_sel <= dec.addr[3:2];
        end
    end

    // fields must not move until the cache takes the header
    a_req_stable: assert property (@(posedge clk) disable iff (!nrst)
        (l15_req.val && !l15_header_ack) |=> $stable(l15_req));

endmodule

`default_nettype wire

/* src/load_align.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load data word select, endian swap and extension
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module load_align import lsu_l15_pkg::*; (
    input  wire l15_resp_t  l15_resp,
    input  wire mem_op_t    ld_op,
    input  wire logic [1:0] ld_baddr,
    input  wire logic [1:0] ld_word_sel,
    input  wire logic       accept,
    output logic [XLEN-1:0] mem_out
);

    logic [XLEN-1:0] rword;
    logic [3:0][7:0] lanes;  // lanes[n] = byte at address offset n
    logic [7:0]      b;
    logic [15:0]     h;

    // upper half of data_0 holds the lowest word
    always_comb begin
        case (ld_word_sel)
            2'b00:   rword = l15_resp.data_0[L15_DW-1:XLEN];
            2'b01:   rword = l15_resp.data_0[XLEN-1:0];
            2'b10:   rword = l15_resp.data_1[L15_DW-1:XLEN];
            default: rword = l15_resp.data_1[XLEN-1:0];
        endcase
    end

    assign lanes = {rword[7:0], rword[15:8], rword[23:16], rword[31:24]};

    assign b = lanes[ld_baddr];
    assign h = {lanes[{ld_baddr[1], 1'b1}], lanes[{ld_baddr[1], 1'b0}]};  // aligned half

    always_comb begin
        mem_out = '0;
        if (accept && !ld_op.store) begin
            case (ld_op.size)
                SZ_WORD: mem_out = lanes;
                SZ_HALF: mem_out = {{16{ld_op.sign & h[15]}}, h};
                SZ_BYTE: mem_out = {{24{ld_op.sign & b[7]}}, b};
                default: mem_out = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/lsu_addr_decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue and decode registers with effective address, alignment
// check, byte enables and store data replication
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lsu_addr_decode import lsu_l15_pkg::*; (
    input  wire logic   clk,
    input  wire logic   nrst,
    input  wire issue_t issue,
    input  wire logic   hold,
    output dec_t        dec
);

    issue_t          iss_q;   // pipe5
    dec_t            dec_d;
    logic [XLEN-1:0] ea;
    logic            mis;
    logic [3:0]      bw;
    logic [XLEN-1:0] wdata;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            iss_q <= '0;
        end else if (!hold) begin
            iss_q <= issue;
        end
    end

    // S offset for stores, I offset for loads
    assign ea = iss_q.op.store ? (iss_q.s_imm + iss_q.op_a)
                               : (iss_q.op_b + iss_q.op_a);

    // halves need bit 0 clear, words need bits 1:0 clear
    assign mis = (iss_q.op.size[0] & ea[0]) | (&iss_q.op.size & ea[1]);

    /*
     lane enables for aligned stores
       word          1111
       half @0 / @2  0011 / 1100
       byte @n       one-hot at n
    */
    always_comb begin
        bw = 4'b0000;
        if (iss_q.op.store && !mis) begin
            case (iss_q.op.size)
                SZ_WORD: bw = 4'b1111;
                SZ_HALF: bw = ea[1] ? 4'b1100 : 4'b0011;
                SZ_BYTE: bw = 4'b0001 << ea[1:0];
                default: bw = 4'b0000;  // not a legal store size
            endcase
        end
    end

    // copy the source into every lane it may land in
    always_comb begin
        case (iss_q.op.size)
            SZ_HALF: wdata = {2{iss_q.op_b[15:0]}};
            SZ_BYTE: wdata = {4{iss_q.op_b[7:0]}};
            default: wdata = iss_q.op_b;
        endcase
    end

    always_comb begin
        dec_d.valid  = |iss_q.op;
        dec_d.op     = iss_q.op;
        dec_d.addr   = ea;
        dec_d.wdata  = wdata;
        dec_d.bw     = bw;
        dec_d.ld_mis = mis & ~iss_q.op.store;
        dec_d.st_mis = mis & iss_q.op.store;
    end

    // pipe6 stays put while a request is outstanding
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            dec <= '0;
        end else if (!hold) begin
            dec <= dec_d;
        end
    end

    // only whole, aligned lane groups ever reach the cache port
    a_bw_legal: assert property (@(posedge clk) disable iff (!nrst)
        dec.bw inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                       4'b0011, 4'b1100, 4'b1111});

endmodule

`default_nettype wire

/* src/lsu_l15_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store unit types: memory-op code, pipeline words,
// L1.5 request and response bundles and their encodings
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lsu_l15_pkg;

    localparam int XLEN   = 32;
    localparam int L15_DW = 64;  // one L1.5 data word

    // size field of the memory-op code
    localparam logic [1:0] SZ_WORD = 2'b11;
    localparam logic [1:0] SZ_HALF = 2'b01;
    localparam logic [1:0] SZ_BYTE = 2'b10;

    // all zero = no memory op
    typedef struct packed {
        logic       store;  // 1 store, 0 load
        logic [1:0] size;
        logic       sign;   // sign-extend loads
    } mem_op_t;

    // operands as the core hands them over
    typedef struct packed {
        mem_op_t         op;
        logic [XLEN-1:0] op_a;   // base
        logic [XLEN-1:0] op_b;   // store source or I offset
        logic [XLEN-1:0] s_imm;  // S offset
    } issue_t;

    typedef struct packed {
        logic            valid;
        mem_op_t         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;  // replicated store data
        logic [3:0]      bw;     // bit 0 = lowest byte address
        logic            ld_mis;
        logic            st_mis;
    } dec_t;

    typedef struct packed {
        logic [4:0]        rqtype;
        logic [2:0]        size;
        logic [XLEN-1:0]   address;
        logic [L15_DW-1:0] data;
        logic              val;
    } l15_req_t;

    typedef struct packed {
        logic [L15_DW-1:0] data_0;
        logic [L15_DW-1:0] data_1;
        logic [3:0]        returntype;
        logic              val;
    } l15_resp_t;

    typedef enum logic [4:0] {
        LOAD_RQ  = 5'd0,
        STORE_RQ = 5'd1
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        LOAD_RET = 4'd0,
        ST_ACK   = 4'd4,
        INT_RET  = 4'd7
    } l15_rettype_e;

    typedef enum logic [2:0] {
        SIZE_0B = 3'd0,
        SIZE_1B = 3'd1,
        SIZE_2B = 3'd2,
        SIZE_4B = 3'd3
    } msg_size_e;

endpackage

`default_nettype wire

/* src/lsu_l15_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store stage in front of the L1.5 port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lsu_l15_top import lsu_l15_pkg::*; (
    input  wire logic      clk,
    input  wire logic      nrst,
    input  wire issue_t    issue,
    output l15_req_t       l15_req,
    input  wire l15_resp_t l15_resp,
    input  wire logic      l15_header_ack,
    output logic           l15_req_ack,
    output logic [XLEN-1:0] mem_out,
    output logic           mem_op_done,
    output logic           mem_busy,      // core must keep issue steady
    output logic           ld_misaligned,
    output logic           st_misaligned
);

    dec_t       dec;
    mem_op_t    ld_op;
    logic [1:0] ld_baddr;
    logic [1:0] ld_word_sel;

    lsu_addr_decode u_decode (
        .clk   (clk),
        .nrst  (nrst),
        .issue (issue),
        .hold  (mem_busy),
        .dec   (dec)
    );

    l15_req_fsm u_fsm (
        .clk            (clk),
        .nrst           (nrst),
        .dec            (dec),
        .l15_resp       (l15_resp),
        .l15_header_ack (l15_header_ack),
        .l15_req        (l15_req),
        .l15_req_ack    (l15_req_ack),
        .hold           (mem_busy),     // same level drives both registers
        .ld_op          (ld_op),
        .ld_baddr       (ld_baddr),
        .ld_word_sel    (ld_word_sel),
        .mem_op_done    (mem_op_done),
        .ld_misaligned  (ld_misaligned),
        .st_misaligned  (st_misaligned)
    );

    load_align u_align (
        .l15_resp    (l15_resp),
        .ld_op       (ld_op),
        .ld_baddr    (ld_baddr),
        .ld_word_sel (ld_word_sel),
        .accept      (mem_op_done),
        .mem_out     (mem_out)
    );

endmodule

`default_nettype wire

/* test/lsu_l15_checks.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// checker on the LSU ports with op scoreboard and assertions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lsu_l15_checks import lsu_l15_pkg::*; (
    input  wire logic            clk,
    input  wire logic            nrst,
    input  wire issue_t          issue,
    input  wire l15_req_t        l15_req,
    input  wire l15_resp_t       l15_resp,
    input  wire logic            l15_header_ack,
    input  wire logic            l15_req_ack,
    input  wire logic [XLEN-1:0] mem_out,
    input  wire logic            mem_op_done,
    input  wire logic            mem_busy,
    input  wire logic            ld_misaligned,
    input  wire logic            st_misaligned,
    output int                   errors,
    output int                   n_aligned,
    output int                   n_done,
    output int                   pending
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        mem_op_t         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] src;   // store source
        logic            mis;
    } exp_t;

    exp_t q[$];    // taken by the issue register and not yet seen at the port
    exp_t e;
    exp_t cur;     // request in flight
    logic busy = 1'b0;
    int   err_cnt = 0;
    int   aligned_cnt = 0;
    int   done_cnt = 0;

    assign errors    = err_cnt;
    assign n_aligned = aligned_cnt;
    assign n_done    = done_cnt;
    assign pending   = q.size() + int'(busy);

    task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
        err_cnt++;
        $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic fail_note(input string what);
        err_cnt++;
        $display("** Error at %0t: %s", $time, what);
    endtask

    function automatic exp_t expect_from(input issue_t i);
        exp_t x;
        x.op   = i.op;
        x.src  = i.op_b;
        x.addr = i.op.store ? i.op_a + i.s_imm : i.op_a + i.op_b;
        case (i.op.size)
            SZ_HALF: x.mis = x.addr[0];
            SZ_WORD: x.mis = (x.addr[1:0] != 2'b00);
            default: x.mis = 1'b0;
        endcase
        return x;
    endfunction

    // loads always fetch 4 bytes from the cache port
    function automatic logic [2:0] exp_size(input mem_op_t op);
        if (!op.store) return SIZE_4B;
        case (op.size)
            SZ_HALF: return SIZE_2B;
            SZ_BYTE: return SIZE_1B;
            default: return SIZE_4B;
        endcase
    endfunction

    function automatic logic [63:0] exp_data(input exp_t x);
        logic [31:0] r;
        logic [31:0] sw;
        case (x.op.size)
            SZ_HALF: r = {x.src[15:0], x.src[15:0]};
            SZ_BYTE: r = {x.src[7:0], x.src[7:0], x.src[7:0], x.src[7:0]};
            default: r = x.src;
        endcase
        sw = {r[7:0], r[15:8], r[23:16], r[31:24]};  // big endian port
        return {sw, sw};
    endfunction

    function automatic logic [31:0] exp_load(input exp_t x, input l15_resp_t r);
        logic [31:0] w;
        logic [31:0] s;
        logic [7:0]  b;
        logic [15:0] h;
        case (x.addr[3:2])
            2'd0:    w = r.data_0[63:32];
            2'd1:    w = r.data_0[31:0];
            2'd2:    w = r.data_1[63:32];
            default: w = r.data_1[31:0];
        endcase
        s = {w[7:0], w[15:8], w[23:16], w[31:24]};  // s[8n+:8] is byte n
        b = s[8*int'(x.addr[1:0]) +: 8];
        h = s[8*int'(x.addr[1:0]) +: 16];
        case (x.op.size)
            SZ_HALF: return x.op.sign ? {{16{h[15]}}, h} : {16'h0, h};
            SZ_BYTE: return x.op.sign ? {{24{b[7]}}, b} : {24'h0, b};
            default: return s;
        endcase
    endfunction

    always @(posedge clk) begin
        if (!nrst) begin
            assert (!l15_req.val) else mismatch("l15_req.val", 64'd0, 64'd1);
            assert (!mem_op_done) else mismatch("mem_op_done", 64'd0, 64'd1);
            assert (!mem_busy) else mismatch("mem_busy", 64'd0, 64'd1);
            assert (!ld_misaligned) else mismatch("ld_misaligned", 64'd0, 64'd1);
            assert (!st_misaligned) else mismatch("st_misaligned", 64'd0, 64'd1);
        end else begin
            if (ld_misaligned || st_misaligned) begin
                assert (!l15_req.val) else mismatch("l15_req.val", 64'd0, 64'd1);
                assert (q.size() != 0) else fail_note("misaligned flag with no op pending");
                if (q.size() != 0) begin
                    e = q.pop_front();
                    assert (e.mis) else fail_note("aligned op flagged as misaligned");
                    assert (ld_misaligned == !e.op.store)
                        else mismatch("ld_misaligned", 64'(!e.op.store), 64'(ld_misaligned));
                    assert (st_misaligned == e.op.store)
                        else mismatch("st_misaligned", 64'(e.op.store), 64'(st_misaligned));
                end
            end
            if (l15_req.val && l15_header_ack) begin
                assert (q.size() != 0) else fail_note("request taken with no op pending");
                if (q.size() != 0) begin
                    e = q.pop_front();
                    assert (!e.mis) else fail_note("misaligned op sent a request");
                    assert (l15_req.rqtype == (e.op.store ? STORE_RQ : LOAD_RQ))
                        else mismatch("l15_req.rqtype", 64'(e.op.store), 64'(l15_req.rqtype));
                    assert (l15_req.size == exp_size(e.op))
                        else mismatch("l15_req.size", 64'(exp_size(e.op)), 64'(l15_req.size));
                    assert (l15_req.address == e.addr)
                        else mismatch("l15_req.address", 64'(e.addr), 64'(l15_req.address));
                    if (e.op.store) begin
                        assert (l15_req.data == exp_data(e))
                            else mismatch("l15_req.data", exp_data(e), l15_req.data);
                    end
                    cur  = e;
                    busy = 1'b1;
                end
            end
            // a return of the other kind must be ignored
            if (busy && l15_resp.val
                && (l15_resp.returntype != (cur.op.store ? ST_ACK : LOAD_RET))) begin
                assert (!mem_op_done) else mismatch("mem_op_done", 64'd0, 64'd1);
            end
            // busy from the taken header up to the matching response
            if (busy && !mem_op_done) begin
                assert (mem_busy) else mismatch("mem_busy", 64'd1, 64'd0);
            end
            if (mem_op_done) begin
                assert (busy) else fail_note("mem_op_done with no request outstanding");
                assert (!mem_busy) else mismatch("mem_busy", 64'd0, 64'd1);
                if (busy && !cur.op.store) begin
                    assert (mem_out == exp_load(cur, l15_resp))
                        else mismatch("mem_out", 64'(exp_load(cur, l15_resp)), 64'(mem_out));
                end
                done_cnt++;
                busy = 1'b0;
            end
            if (!mem_busy && issue.op != 4'b0000) begin  // issue register takes it now
                e = expect_from(issue);
                q.push_back(e);
                if (!e.mis) aligned_cnt++;
            end
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!nrst)
        (l15_req.val && !l15_header_ack) |=> (l15_req.val && $stable(l15_req)))
        else fail_note("l15_req moved or dropped before l15_header_ack");

    a_ack_mirror: assert property (@(posedge clk) l15_req_ack == l15_resp.val)
        else mismatch("l15_req_ack", 64'(l15_resp.val), 64'(l15_req_ack));

    a_out_idle: assert property (@(posedge clk) !mem_op_done |-> (mem_out == '0))
        else mismatch("mem_out", 64'd0, 64'(mem_out));

endmodule

`default_nettype wire

/* test/lsu_l15_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU testbench with clock, reset, L1.5 model, stimulus and watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lsu_l15_tb import lsu_l15_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_OPS  = 40;
    localparam int OP_CYC = 20;
    localparam int LIMIT_NS = (8 + N_OPS * OP_CYC) * 10;

    // {store, size, sign}
    localparam mem_op_t OP_SW  = 4'b1110;
    localparam mem_op_t OP_SH  = 4'b1010;
    localparam mem_op_t OP_SB  = 4'b1100;
    localparam mem_op_t OP_LW  = 4'b0110;
    localparam mem_op_t OP_LH  = 4'b0011;
    localparam mem_op_t OP_LHU = 4'b0010;
    localparam mem_op_t OP_LB  = 4'b0101;
    localparam mem_op_t OP_LBU = 4'b0100;

    logic            clk = 1'b0;
    logic            nrst;
    issue_t          issue;
    l15_req_t        l15_req;
    l15_resp_t       l15_resp;
    logic            l15_header_ack;
    logic            l15_req_ack;
    logic [XLEN-1:0] mem_out;
    logic            mem_op_done, mem_busy, ld_misaligned, st_misaligned;
    int              chk_errors, n_aligned, n_done, pending;
    int              end_errors = 0;
    logic [31:0]     lfsr_state = 32'hb0c23a01;
    logic [31:0]     base, r;
    mem_op_t         op_table [8];

    always #5 clk = ~clk;

    lsu_l15_top DUT (.*);

    lsu_l15_checks chk (.*, .errors(chk_errors));

    // one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) lfsr_state = lfsr_state ^ 32'h80200003;
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    // hold one op on the bus until the issue register takes it
    task automatic issue_op(input mem_op_t op, input logic [31:0] a, input logic [31:0] off);
        @(negedge clk);
        issue.op    = op;
        issue.op_a  = a;
        issue.op_b  = op.store ? lfsr_bits(32) : off;
        issue.s_imm = op.store ? off : lfsr_bits(32);  // unused offset gets noise
        #1;
        while (mem_busy) begin
            @(negedge clk);
            #1;
        end
    endtask

    // L1.5 model acks a header after 0-3 cycles and answers 1-4 cycles later
    initial begin : l15_model
        int   d;
        logic st;
        l15_header_ack = 1'b0;
        l15_resp       = '0;
        forever begin
            @(negedge clk);
            if (nrst && l15_req.val) begin
                st = (l15_req.rqtype == STORE_RQ);
                d = int'(lfsr_bits(2));
                repeat (d) @(negedge clk);
                l15_header_ack = 1'b1;
                @(negedge clk);
                l15_header_ack = 1'b0;
                d = int'(lfsr_bits(2));
                repeat (d) @(negedge clk);
                if (lfsr_bits(2) == 32'd0) begin  // now and then a wrong kind first
                    l15_resp.returntype = st ? LOAD_RET : ST_ACK;
                    l15_resp.data_0     = {lfsr_bits(32), lfsr_bits(32)};
                    l15_resp.data_1     = {lfsr_bits(32), lfsr_bits(32)};
                    l15_resp.val        = 1'b1;
                    @(negedge clk);
                end
                l15_resp.returntype = st ? ST_ACK : LOAD_RET;
                l15_resp.data_0     = {lfsr_bits(32), lfsr_bits(32)};
                l15_resp.data_1     = {lfsr_bits(32), lfsr_bits(32)};
                l15_resp.val        = 1'b1;
                @(negedge clk);
                l15_resp = '0;
            end
        end
    end

    initial begin : watchdog
        #(LIMIT_NS);
        $display("watchdog: operations did not complete in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        issue = '0;
        nrst  = 1'b0;
        op_table = '{OP_SW, OP_SH, OP_SB, OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
        repeat (8) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        r = lfsr_bits(28);
        base = {r[27:0], 4'h0};
        issue_op(OP_SW, base, 32'd0);
        for (int k = 0; k < 2; k++) issue_op(OP_SH, base, 32'(2 * k));
        for (int k = 0; k < 4; k++) issue_op(OP_SB, base, 32'(k));

        r = lfsr_bits(28);
        base = {r[27:0], 4'h0};
        for (int k = 0; k < 4; k++) issue_op(OP_LW, base, 32'(4 * k));
        for (int k = 0; k < 4; k++) issue_op(OP_LH, base, 32'(6 * k));
        for (int k = 0; k < 4; k++) issue_op(OP_LHU, base, 32'(6 * k + 2));
        for (int k = 0; k < 4; k++) issue_op(OP_LB, base, 32'(5 * k));
        for (int k = 0; k < 4; k++) issue_op(OP_LBU, base, 32'(3 * k + 1));

        // odd halves and unaligned words
        issue_op(OP_SH, base, 32'd1);
        issue_op(OP_SW, base, 32'd2);
        issue_op(OP_LH, base, 32'd3);
        issue_op(OP_LW, base, 32'd5);

        for (int k = 0; k < 8; k++) begin
            r = lfsr_bits(7);
            issue_op(op_table[r[6:4]], base, {28'd0, r[3:0]});
        end
        @(negedge clk);
        issue = '0;
        while (pending != 0 || mem_busy) @(negedge clk);
        repeat (3) @(negedge clk);

        assert (n_done == n_aligned) else begin
            end_errors++;
            $display("mem_op_done seen %0d times for %0d aligned ops", n_done, n_aligned);
        end
        $display("errors: %0d (checker %0d, end of run %0d)",
                 chk_errors + end_errors, chk_errors, end_errors);
        if (chk_errors + end_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
